//--- common/ldpc_ibuf_consts.svh
// widths, lane counts and block length of the LLR input buffer
// shared by the package, the RTL and the testbench

`ifndef LDPC_IBUF_CONSTS_SVH
`define LDPC_IBUF_CONSTS_SVH

// --------------------
// LLR word layout
// --------------------
`define LLR_W          5   // bits per signed LLR
`define LLR_BY_CYCLE   2   // LLRs packed in one RAM word
`define NODE_BY_CYCLE  2   // node lanes, one RAM each

// --------------------
// addressing and tags
// --------------------
`define ADDR_W         4   // word address inside one bank
`define TAG_W          8   // block tag

// words per codeword, one full bank by default
`define BLOCK_LEN      (1 << `ADDR_W)

`endif

//--- common/ldpc_ibuf_pkg.sv
// LLR and tag types, fetch engine states

package ldpc_ibuf_pkg;

  `include "ldpc_ibuf_consts.svh"

  // --------------------
  // payload types
  // --------------------

  // one channel LLR, two's complement
  typedef logic signed [`LLR_W-1:0] llr_t;

  // block tag, travels from the writer to the stream out
  typedef logic [`TAG_W-1:0] tag_t;

  // --------------------
  // fetch FSM
  // --------------------

  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // waiting for a full bank
    READ  = 2'd1,  // issuing addresses
    DRAIN = 2'd2   // last words still in the RAM pipe
  } fetch_state_t;

endpackage

//--- ibuffer/codec_buffer_nD_slogic.sv
// bank pointers and full-bank count of the ping-pong buffer
// with the any/all empty and full flags

`timescale 1ns/100ps

module codec_buffer_nD_slogic (
  input  logic iclk,
  input  logic rst_n,
  input  logic iclkena,
  // write side
  input  logic wfull,      // writer hands over its bank
  output logic b_wused,    // bank being written
  // read side
  input  logic rempty,     // reader releases its bank
  output logic b_rused,    // bank being read
  // status
  output logic empty_any,  // at least one bank free
  output logic empty_all,  // both banks free
  output logic full_any,   // at least one bank ready to read
  output logic full_all    // both banks ready, writer must wait
);

  logic [1:0] full_cnt;  // banks holding a codeword, 0..2

  logic do_wfull;
  logic do_rempty;

  assign do_wfull  = iclkena & wfull;
  assign do_rempty = iclkena & rempty;

  // --------------------
  // pointers and count
  // --------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      b_wused  <= 1'b0;
      b_rused  <= 1'b0;
      full_cnt <= 2'd0;
    end else begin
      if (do_wfull) begin
        b_wused <= ~b_wused;  // next bank for the writer
      end
      if (do_rempty) begin
        b_rused <= ~b_rused;
      end
      // both at once leave the count alone
      case ({do_wfull, do_rempty})
        2'b10:   full_cnt <= full_cnt + 2'd1;
        2'b01:   full_cnt <= full_cnt - 2'd1;
        default: full_cnt <= full_cnt;
      endcase
    end
  end

  // --------------------
  // flags
  // --------------------

  assign empty_any = (full_cnt < 2'd2);
  assign empty_all = (full_cnt == 2'd0);
  assign full_any  = (full_cnt != 2'd0);
  assign full_all  = (full_cnt == 2'd2);

  // writer may not overrun both banks, reader may not release a free one
  a_no_wfull_when_full: assert property (
    @(posedge iclk) disable iff (!rst_n)
    (iclkena && wfull) |-> (full_cnt != 2'd2)
  ) else $error("wfull while both banks are full");

  a_no_rempty_when_empty: assert property (
    @(posedge iclk) disable iff (!rst_n)
    (iclkena && rempty) |-> (full_cnt != 2'd0)
  ) else $error("rempty while no bank is full");

endmodule

//--- ibuffer/codec_mem_block.sv
// simple dual-port register RAM, two-cycle read
// registered read address followed by an output register

`timescale 1ns/100ps

module codec_mem_block #(
  parameter int ADDR_W = 5,
  parameter int DAT_W  = 10
) (
  input  logic              iclk,
  input  logic              rst_n,
  input  logic              iclkena,
  // write port
  input  logic              write,
  input  logic [ADDR_W-1:0] waddr,
  input  logic [DAT_W-1:0]  wdat,
  // read port
  input  logic [ADDR_W-1:0] raddr,
  output logic [DAT_W-1:0]  rdat
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DAT_W-1:0]  mem [DEPTH];
  logic [ADDR_W-1:0] raddr_q;  // read stage 1

  // --------------------
  // write port
  // --------------------

  always_ff @(posedge iclk) begin
    if (iclkena && write) begin
      mem[waddr] <= wdat;
    end
  end

  // --------------------
  // read pipeline
  // --------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      raddr_q <= raddr;  // address register
    end
  end

  // array read after the address stage, so last cycle's write is seen
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      rdat <= '0;
    end else if (iclkena) begin
      rdat <= mem[raddr_q];  // read stage 2
    end
  end

endmodule

//--- ibuffer/ldpc_dec_ibuffer.sv
// two-bank LLR input buffer: bank state logic, one RAM per node lane
// and a two-entry tag store

`timescale 1ns/100ps

`include "ldpc_ibuf_consts.svh"

module ldpc_dec_ibuffer #(
  parameter int LLR_W         = `LLR_W,
  parameter int LLR_BY_CYCLE  = `LLR_BY_CYCLE,
  parameter int NODE_BY_CYCLE = `NODE_BY_CYCLE,
  parameter int ADDR_W        = `ADDR_W
) (
  input  logic                     iclk,
  input  logic                     rst_n,
  input  logic                     iclkena,
  // write side
  input  logic [NODE_BY_CYCLE-1:0] write,  // per lane strobe
  input  logic                     wfull,
  input  logic [ADDR_W-1:0]        waddr,
  input  ldpc_ibuf_pkg::llr_t      wllr [LLR_BY_CYCLE],
  input  ldpc_ibuf_pkg::tag_t      wtag,
  // read side
  input  logic                     rempty,
  input  logic [ADDR_W-1:0]        raddr,
  output ldpc_ibuf_pkg::llr_t      rllr [LLR_BY_CYCLE][NODE_BY_CYCLE],
  output ldpc_ibuf_pkg::tag_t      rtag,
  // status
  output logic                     empty_any,
  output logic                     empty_all,
  output logic                     full_any,
  output logic                     full_all
);

  import ldpc_ibuf_pkg::*;

  localparam int MEM_ADDR_W = ADDR_W + 1;            // bank bit on top
  localparam int MEM_DAT_W  = LLR_BY_CYCLE * LLR_W;

  logic b_wused;
  logic b_rused;

  // --------------------
  // bank state
  // --------------------

  codec_buffer_nD_slogic slogic_i (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .iclkena   (iclkena),
    .wfull     (wfull),
    .b_wused   (b_wused),
    .rempty    (rempty),
    .b_rused   (b_rused),
    .empty_any (empty_any),
    .empty_all (empty_all),
    .full_any  (full_any),
    .full_all  (full_all)
  );

  // --------------------
  // LLR RAMs
  // --------------------

  logic [MEM_DAT_W-1:0] mem_wdat;
  logic [MEM_DAT_W-1:0] mem_rdat [NODE_BY_CYCLE];

  // pack on write, unpack per lane on read
  always_comb begin
    for (int l = 0; l < LLR_BY_CYCLE; l++) begin
      mem_wdat[l*LLR_W +: LLR_W] = wllr[l];
      for (int n = 0; n < NODE_BY_CYCLE; n++) begin
        rllr[l][n] = mem_rdat[n][l*LLR_W +: LLR_W];
      end
    end
  end

  for (genvar gn = 0; gn < NODE_BY_CYCLE; gn++) begin : g_lane
    codec_mem_block #(
      .ADDR_W (MEM_ADDR_W),
      .DAT_W  (MEM_DAT_W)
    ) mem_i (
      .iclk    (iclk),
      .rst_n   (rst_n),
      .iclkena (iclkena),
      .write   (write[gn]),
      .waddr   ({b_wused, waddr}),  // writer owns one bank
      .wdat    (mem_wdat),
      .raddr   ({b_rused, raddr}),  // reader the other
      .rdat    (mem_rdat[gn])
    );
  end

  // --------------------
  // tag store
  // --------------------

  tag_t tag_ram [2];  // one tag per bank

  always_ff @(posedge iclk) begin
    if (iclkena && wfull) begin
      tag_ram[b_wused] <= wtag;  // tag lands with the bank handover
    end
  end

  assign rtag = tag_ram[b_rused];  // comb, follows the read bank

endmodule

//--- design/ldpc_dec_fetch.sv
// fetch engine that reads each full bank in address order, aligns the strobes
// to the two-cycle RAM read and releases the bank on the last word

`timescale 1ns/100ps

`include "ldpc_ibuf_consts.svh"

module ldpc_dec_fetch (
  input  logic                iclk,
  input  logic                rst_n,
  input  logic                iclkena,
  // buffer read side
  input  logic                full_any,
  output logic [`ADDR_W-1:0]  raddr,
  output logic                rempty,
  input  ldpc_ibuf_pkg::llr_t rllr [`LLR_BY_CYCLE][`NODE_BY_CYCLE],
  input  ldpc_ibuf_pkg::tag_t rtag,
  // stream out
  output ldpc_ibuf_pkg::llr_t llr [`LLR_BY_CYCLE][`NODE_BY_CYCLE],
  output logic                llr_val,
  output logic                llr_sop,
  output logic                llr_eop,
  output ldpc_ibuf_pkg::tag_t llr_tag
);

  import ldpc_ibuf_pkg::*;

  localparam logic [`ADDR_W-1:0] LAST_ADDR = `ADDR_W'(`BLOCK_LEN - 1);

  fetch_state_t       state;
  logic [`ADDR_W-1:0] addr_cnt;
  logic               issue;      // address goes out this cycle
  logic               start;      // first address of a block
  logic               addr_last;
  logic [1:0]         val_pipe;   // matches RAM latency
  logic [1:0]         sop_pipe;
  logic [1:0]         eop_pipe;
  tag_t               tag_q;

  // --------------------
  // FSM and address counter
  // --------------------

  assign start     = (state == IDLE) && full_any;  // addr 0 issued in IDLE
  assign issue     = start || (state == READ);
  assign addr_last = (addr_cnt == LAST_ADDR);
  assign raddr     = addr_cnt;                      // 0 while idle

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      state    <= IDLE;
      addr_cnt <= '0;
    end else if (iclkena) begin
      if (issue) begin
        addr_cnt <= addr_last ? '0 : addr_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          if (full_any) begin
            state <= addr_last ? DRAIN : READ;  // one-word block goes straight on
          end
        end
        READ: begin
          if (addr_last) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (eop_pipe[1]) begin
            state <= IDLE;  // bank released this cycle
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // strobe alignment
  // --------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      val_pipe <= '0;
      sop_pipe <= '0;
      eop_pipe <= '0;
    end else if (iclkena) begin
      val_pipe <= {val_pipe[0], issue};
      sop_pipe <= {sop_pipe[0], start};
      eop_pipe <= {eop_pipe[0], issue & addr_last};
    end
  end

  // tag fixed for the whole block
  always_ff @(posedge iclk) begin
    if (iclkena && start) begin
      tag_q <= rtag;
    end
  end

  assign llr     = rllr;  // RAM output already two cycles behind raddr
  assign llr_val = val_pipe[1];
  assign llr_sop = sop_pipe[1];
  assign llr_eop = eop_pipe[1];
  assign llr_tag = tag_q;
  assign rempty  = eop_pipe[1];  // frees the bank with the last word

  // frame strobes only on valid words of a bank still held full
  a_strobe_with_val: assert property (
    @(posedge iclk) disable iff (!rst_n)
    (llr_sop || llr_eop) |-> (llr_val && full_any)
  ) else $error("llr_sop or llr_eop without llr_val or without a full bank");

endmodule

//--- design/ldpc_ibuf_top.sv
// LDPC decoder input side: ping-pong LLR buffer feeding the fetch engine

`timescale 1ns/100ps

`include "ldpc_ibuf_consts.svh"

module ldpc_ibuf_top (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,     // global enable, only back-pressure
  // channel writer
  input  logic [`NODE_BY_CYCLE-1:0] write,
  input  logic                      wfull,
  input  logic [`ADDR_W-1:0]        waddr,
  input  ldpc_ibuf_pkg::llr_t       wllr [`LLR_BY_CYCLE],
  input  ldpc_ibuf_pkg::tag_t       wtag,
  // LLR stream
  output ldpc_ibuf_pkg::llr_t       llr [`LLR_BY_CYCLE][`NODE_BY_CYCLE],
  output logic                      llr_val,
  output logic                      llr_sop,
  output logic                      llr_eop,
  output ldpc_ibuf_pkg::tag_t       llr_tag,
  // status
  output logic                      buf_empty,  // both banks free
  output logic                      buf_full    // both banks waiting
);

  import ldpc_ibuf_pkg::*;

  // buffer to fetch
  logic               full_any;
  logic               rempty;
  logic [`ADDR_W-1:0] raddr;
  llr_t               rllr [`LLR_BY_CYCLE][`NODE_BY_CYCLE];
  tag_t               rtag;

  ldpc_dec_ibuffer ibuffer_i (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .iclkena   (clkena),
    .write     (write),
    .wfull     (wfull),
    .waddr     (waddr),
    .wllr      (wllr),
    .wtag      (wtag),
    .rempty    (rempty),
    .raddr     (raddr),
    .rllr      (rllr),
    .rtag      (rtag),
    .empty_any (),
    .empty_all (buf_empty),
    .full_any  (full_any),
    .full_all  (buf_full)
  );

  ldpc_dec_fetch fetch_i (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .iclkena  (clkena),
    .full_any (full_any),
    .raddr    (raddr),
    .rempty   (rempty),
    .rllr     (rllr),
    .rtag     (rtag),
    .llr      (llr),
    .llr_val  (llr_val),
    .llr_sop  (llr_sop),
    .llr_eop  (llr_eop),
    .llr_tag  (llr_tag)
  );

endmodule

//--- bench/ldpc_ibuf_tb.sv
// testbench for the LLR input buffer: block table, writer with stalls,
// scoreboard monitor, single check task and cycle timeout

`timescale 1ns/100ps

`include "ldpc_ibuf_consts.svh"

module ldpc_ibuf_tb;

  import ldpc_ibuf_pkg::*;

  localparam int N_BLK   = 6;
  localparam int WORD_W  = `LLR_BY_CYCLE * `NODE_BY_CYCLE * `LLR_W;  // one stream word
  localparam int TIMEOUT = N_BLK * (`BLOCK_LEN + 8) * 4 + 100;

  // --------------------
  // block table
  // --------------------
  tag_t                      tbl_tag   [N_BLK] = '{8'h11, 8'h2c, 8'h3a, 8'h47, 8'h5e, 8'h6f};
  bit                        tbl_rand  [N_BLK] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
  logic [`NODE_BY_CYCLE-1:0] tbl_mask  [N_BLK] = '{default: '1};  // every lane written
  bit                        tbl_stall [N_BLK] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
  int                        tbl_base  [N_BLK] = '{0, 3, -9, 0, 12, 0};  // seq start value

  logic                      iclk;
  logic                      rst_n;
  logic                      clkena;
  logic [`NODE_BY_CYCLE-1:0] write;
  logic                      wfull;
  logic [`ADDR_W-1:0]        waddr;
  llr_t                      wllr [`LLR_BY_CYCLE];
  tag_t                      wtag;
  llr_t                      llr [`LLR_BY_CYCLE][`NODE_BY_CYCLE];
  logic                      llr_val;
  logic                      llr_sop;
  logic                      llr_eop;
  tag_t                      llr_tag;
  logic                      buf_empty;
  logic                      buf_full;

  integer seed;
  int     checks       = 0;
  int     val_errors   = 0;
  int     other_errors = 0;
  int     cycle_cnt    = 0;
  int     neg_seen     = 0;   // negative LLRs seen on the stream
  int     wfull_cnt    = 0;   // accepted handovers
  bit     full_seen    = 1'b0;
  logic   edge_en      = 1'b0;  // last posedge moved the DUT

  // scoreboard, one entry per expected word
  logic [WORD_W-1:0] exp_word_q [$];
  int                exp_addr_q [$];
  tag_t              exp_tag_q  [$];

  initial iclk = 1'b0;
  always #50 iclk = ~iclk;  // 100 ns period

  ldpc_ibuf_top dut_i (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .clkena    (clkena),
    .write     (write),
    .wfull     (wfull),
    .waddr     (waddr),
    .wllr      (wllr),
    .wtag      (wtag),
    .llr       (llr),
    .llr_val   (llr_val),
    .llr_sop   (llr_sop),
    .llr_eop   (llr_eop),
    .llr_tag   (llr_tag),
    .buf_empty (buf_empty),
    .buf_full  (buf_full)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      val_errors++;
      $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // one enabled edge, clkena dropped for a random stretch first when stalling
  task automatic advance(input bit stall);
    int gap;
    gap = 0;
    if (stall && ($random(seed) % 3 == 0)) begin
      gap = 1 + ($unsigned($random(seed)) % 4);
    end
    if (gap > 0) begin
      clkena = 1'b0;               // freeze both sides
      repeat (gap) @(negedge iclk);
    end
    clkena = 1'b1;
    @(negedge iclk);
  endtask

  // --------------------
  // writer
  // --------------------
  task automatic write_block(input int idx);
    logic [WORD_W-1:0] word;
    llr_t              v;
    while (buf_full) advance(1'b0);  // no free bank yet
    for (int a = 0; a < `BLOCK_LEN; a++) begin
      word = '0;
      for (int l = 0; l < `LLR_BY_CYCLE; l++) begin
        if (tbl_rand[idx]) begin
          v = llr_t'($random(seed));
        end else begin
          v = llr_t'(tbl_base[idx] + a + l);  // wraps to LLR_W bits
        end
        wllr[l] = v;
        for (int n = 0; n < `NODE_BY_CYCLE; n++) begin
          word[(l*`NODE_BY_CYCLE + n)*`LLR_W +: `LLR_W] = v;  // wllr shared by lanes
        end
      end
      exp_word_q.push_back(word);
      exp_addr_q.push_back(a);
      exp_tag_q.push_back(tbl_tag[idx]);
      write = tbl_mask[idx];
      waddr = `ADDR_W'(a);
      advance(tbl_stall[idx]);
    end
    write = '0;
    while (buf_full) advance(1'b0);
    wfull = 1'b1;  // bank handover with its tag
    wtag  = tbl_tag[idx];
    advance(tbl_stall[idx]);
    wfull = 1'b0;
    wfull_cnt++;
  endtask

  // --------------------
  // monitor
  // --------------------
  task automatic check_word();
    logic [WORD_W-1:0] word;
    int                addr;
    tag_t              tag;
    llr_t              exp_l;
    if (wfull_cnt == 0) begin
      other_errors++;
      $display("error: llr_val high before any block was handed over at %0t", $time);
    end
    if (exp_word_q.size() == 0) begin
      other_errors++;
      $display("error: extra word on the stream, scoreboard is empty at %0t", $time);
      return;
    end
    word = exp_word_q.pop_front();
    addr = exp_addr_q.pop_front();
    tag  = exp_tag_q.pop_front();
    for (int l = 0; l < `LLR_BY_CYCLE; l++) begin
      for (int n = 0; n < `NODE_BY_CYCLE; n++) begin
        exp_l = llr_t'(word[(l*`NODE_BY_CYCLE + n)*`LLR_W +: `LLR_W]);
        check_value($sformatf("llr[%0d][%0d]", l, n), 32'(exp_l), 32'(llr[l][n]));
        if (llr[l][n] < 0) neg_seen++;
      end
    end
    check_value("llr_sop", 32'(addr == 0), 32'(llr_sop));
    check_value("llr_eop", 32'(addr == `BLOCK_LEN - 1), 32'(llr_eop));
    check_value("llr_tag", 32'(tag), 32'(llr_tag));
  endtask

  always @(posedge iclk) edge_en <= rst_n && clkena;

  // outputs read mid-cycle, one word per enabled edge
  always @(negedge iclk) begin
    if (rst_n && buf_full) full_seen = 1'b1;
    if (edge_en && llr_val) check_word();
  end

  always @(posedge iclk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout: stream not finished after %0d cycles", TIMEOUT);
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, val_errors, other_errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    seed   = 32'h6aab;
    rst_n  = 1'b0;
    clkena = 1'b1;
    write  = '0;
    wfull  = 1'b0;
    waddr  = '0;
    wtag   = '0;
    for (int l = 0; l < `LLR_BY_CYCLE; l++) wllr[l] = '0;
    repeat (3) @(negedge iclk);  // reset for 3 cycles
    rst_n = 1'b1;
    check_value("buf_empty", 32'h1, 32'(buf_empty));
    check_value("buf_full", 32'h0, 32'(buf_full));
    check_value("llr_val", 32'h0, 32'(llr_val));
    for (int i = 0; i < N_BLK; i++) begin
      write_block(i);  // back to back, reader overlaps
    end
    while (exp_word_q.size() != 0) advance(1'b0);
    repeat (4) advance(1'b0);  // catch trailing extra words
    check_value("buf_empty", 32'h1, 32'(buf_empty));
    if (!full_seen) begin
      other_errors++;
      $display("error: buf_full never went high during back-to-back blocks");
    end
    if (neg_seen == 0) begin
      other_errors++;
      $display("error: no negative LLR came out of the stream");
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, val_errors, other_errors);
    if (val_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- ldpc_ibuf.f
+incdir+common
common/ldpc_ibuf_pkg.sv
ibuffer/codec_buffer_nD_slogic.sv
ibuffer/codec_mem_block.sv
ibuffer/ldpc_dec_ibuffer.sv
design/ldpc_dec_fetch.sv
design/ldpc_ibuf_top.sv
bench/ldpc_ibuf_tb.sv

//--- Makefile
# Verilator lint, simulation and clean for the LDPC input buffer
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= ldpc_ibuf_tb
RTL_TOP   ?= ldpc_ibuf_top
FILELIST  ?= ldpc_ibuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP) $(VFLAGS)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) $(VFLAGS)

# the pipe hides the exit code, the log search decides
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "run FAILED, see $(LOG)"; exit 1; }
	@echo "run OK, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
